//--- pe_core.f
+incdir+source
source/pe_pkg.sv
source/pe_if.sv
source/inst_mem.sv
source/data_mem.sv
source/pe_control.sv
source/complex_alu.sv
source/pe_core.sv
dv/pe_core_tb.sv

//--- dv/pe_core_tb.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module pe_core_tb;

    localparam int N_OPS    = 20;
    localparam int N_INST   = 13;
    localparam int HALT_IDX = 12;
    // cycles watched after start, done plus a quiet tail
    localparam int RUN_CYC  = HALT_IDX + 8;
    localparam int WD_CYC   = 200 + N_OPS + N_INST;

    logic                      clk;
    logic                      arst_n;
    logic                      din_v;
    logic [`PE_DATA_WIDTH-1:0] din_re;
    logic [`PE_DATA_WIDTH-1:0] din_im;
    logic                      inst_in_v;
    logic [`PE_INST_WIDTH-1:0] inst_in;
    logic                      start;
    logic                      dout_v;
    logic [`PE_DATA_WIDTH-1:0] dout_re;
    logic [`PE_DATA_WIDTH-1:0] dout_im;
    logic                      fwd_v;
    logic [`PE_DATA_WIDTH-1:0] fwd_re;
    logic [`PE_DATA_WIDTH-1:0] fwd_im;
    logic                      done;
    logic                      busy;

    int seed;
    int mism_cnt;
    int fail_cnt;

    // stimulus and expected tables
    pe_pkg::cplx_t ops [N_OPS];
    pe_pkg::inst_t prog [N_INST];
    pe_pkg::cplx_t ref_rf [`PE_REG_NUM];
    // indexed by cycle offset from start
    logic          exp_v [RUN_CYC+1];
    pe_pkg::cplx_t exp_val [RUN_CYC+1];

    pe_core dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .din_v     (din_v),
        .din_re    (din_re),
        .din_im    (din_im),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .start     (start),
        .dout_v    (dout_v),
        .dout_re   (dout_re),
        .dout_im   (dout_im),
        .fwd_v     (fwd_v),
        .fwd_re    (fwd_re),
        .fwd_im    (fwd_im),
        .done      (done),
        .busy      (busy)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // model and table helpers
    //////////////////////////////
    function automatic pe_pkg::inst_t make_inst(pe_pkg::op_e op, logic out_en,
                                                int dst, int src_a, int src_b);
        pe_pkg::inst_t w;
        w.op     = op;
        w.out_en = out_en;
        w.dst    = dst[`PE_REG_ADDR_WIDTH-1:0];
        w.src_a  = src_a[`PE_REG_ADDR_WIDTH-1:0];
        w.src_b  = src_b[`PE_REG_ADDR_WIDTH-1:0];
        return w;
    endfunction

    // complex math on 16 bit components, results wrap
    function automatic pe_pkg::cplx_t ref_calc(pe_pkg::op_e op, pe_pkg::cplx_t a,
                                               pe_pkg::cplx_t b);
        pe_pkg::cplx_t r;
        r = '0;
        case (op)
            pe_pkg::OP_ADD: begin
                r.re = a.re + b.re;
                r.im = a.im + b.im;
            end
            pe_pkg::OP_SUB: begin
                r.re = a.re - b.re;
                r.im = a.im - b.im;
            end
            pe_pkg::OP_MUL: begin
                r.re = a.re * b.re - a.im * b.im;
                r.im = a.re * b.im + a.im * b.re;
            end
            // a times conj(b)
            pe_pkg::OP_CMUL: begin
                r.re = a.re * b.re + a.im * b.im;
                r.im = a.im * b.re - a.re * b.im;
            end
            default: begin
                r = '0;
            end
        endcase
        return r;
    endfunction

    task automatic build_tables();
        int            k;
        pe_pkg::cplx_t res;
        for (k = 0; k < N_OPS; k++) begin
            ops[k] = $random(seed);
        end
        // first wave, all four ops on loaded values
        prog[0]  = make_inst(pe_pkg::OP_ADD,  1'b1, 12, 0, 1);
        prog[1]  = make_inst(pe_pkg::OP_SUB,  1'b1, 13, 2, 3);
        prog[2]  = make_inst(pe_pkg::OP_MUL,  1'b1, 14, 4, 5);
        // overwrites loaded r1
        prog[3]  = make_inst(pe_pkg::OP_CMUL, 1'b1, 1, 6, 7);
        // silent results, seen only through later reads
        prog[4]  = make_inst(pe_pkg::OP_MUL,  1'b0, 2, 8, 9);
        prog[5]  = make_inst(pe_pkg::OP_CMUL, 1'b0, 3, 10, 11);
        // chained, each source written three or more earlier
        prog[6]  = make_inst(pe_pkg::OP_ADD,  1'b1, 4, 1, 12);
        prog[7]  = make_inst(pe_pkg::OP_SUB,  1'b1, 5, 2, 13);
        prog[8]  = make_inst(pe_pkg::OP_MUL,  1'b1, 15, 3, 14);
        prog[9]  = make_inst(pe_pkg::OP_NOP,  1'b0, 0, 0, 0);
        prog[10] = make_inst(pe_pkg::OP_CMUL, 1'b1, 0, 4, 5);
        prog[11] = make_inst(pe_pkg::OP_ADD,  1'b1, 6, 15, 1);
        prog[12] = make_inst(pe_pkg::OP_HALT, 1'b0, 0, 0, 0);
        // spacing rule holds, so program order gives the pipelined values
        for (k = 0; k < `PE_REG_NUM; k++) begin
            ref_rf[k] = ops[k];
        end
        for (k = 0; k <= RUN_CYC; k++) begin
            exp_v[k]   = 1'b0;
            exp_val[k] = '0;
        end
        for (k = 0; k < N_INST; k++) begin
            if (prog[k].op inside {pe_pkg::OP_ADD, pe_pkg::OP_SUB,
                                   pe_pkg::OP_MUL, pe_pkg::OP_CMUL}) begin
                res = ref_calc(prog[k].op, ref_rf[prog[k].src_a], ref_rf[prog[k].src_b]);
                ref_rf[prog[k].dst] = res;
                // result lands at start + k + 4
                if (prog[k].out_en) begin
                    exp_v[k+4]   = 1'b1;
                    exp_val[k+4] = res;
                end
            end
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_cplx(string name, pe_pkg::cplx_t act, pe_pkg::cplx_t exp);
        if (act !== exp) begin
            mism_cnt++;
            $display("Mismatch at %0t: %s got re=%h im=%h, expected re=%h im=%h",
                     $time, name, act.re, act.im, exp.re, exp.im);
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            mism_cnt++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, act, exp);
        end
    endtask

    task automatic report_error(string msg);
        fail_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // watchdog
    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", WD_CYC);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int i;
        seed      = 55;
        mism_cnt  = 0;
        fail_cnt  = 0;
        arst_n    = 1'b0;
        din_v     = 1'b0;
        din_re    = '0;
        din_im    = '0;
        inst_in_v = 1'b0;
        inst_in   = '0;
        start     = 1'b0;
        build_tables();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // quiet after reset
        repeat (5) begin
            @(negedge clk);
            check_bit("dout_v", dout_v, 1'b0);
            check_bit("fwd_v", fwd_v, 1'b0);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
        end

        // operands and program load together, fwd checked one cycle later
        for (i = 0; i <= N_OPS; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_bit("fwd_v", fwd_v, (i - 1) >= `PE_REG_NUM);
                if ((i - 1) >= `PE_REG_NUM) begin
                    check_cplx("fwd", {fwd_re, fwd_im}, ops[i-1]);
                end
            end
            din_v     = (i < N_OPS);
            inst_in_v = (i < N_INST);
            if (i < N_OPS) begin
                din_re = ops[i].re;
                din_im = ops[i].im;
            end else begin
                din_re = '0;
                din_im = '0;
            end
            if (i < N_INST) begin
                inst_in = prog[i];
            end else begin
                inst_in = '0;
            end
        end
        @(negedge clk);
        check_bit("fwd_v", fwd_v, 1'b0);

        // run, i counts cycles after the start cycle
        check_bit("busy", busy, 1'b0);
        start = 1'b1;
        for (i = 1; i <= RUN_CYC; i++) begin
            @(negedge clk);
            // second start while busy, must be dropped
            start = (i == 3);
            if (exp_v[i]) begin
                if (dout_v !== 1'b1) begin
                    report_error($sformatf("missing dout_v in run cycle %0d", i));
                end else begin
                    check_cplx("dout", {dout_re, dout_im}, exp_val[i]);
                end
            end else if (dout_v !== 1'b0) begin
                report_error($sformatf("extra dout_v in run cycle %0d", i));
            end
            if (i == HALT_IDX + 4) begin
                if (done !== 1'b1) begin
                    report_error($sformatf("missing done in run cycle %0d", i));
                end
            end else begin
                check_bit("done", done, 1'b0);
            end
            check_bit("busy", busy, i < HALT_IDX + 4);
        end

        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt + fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- source/pe_core.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module pe_core (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      din_v,
    input  logic [`PE_DATA_WIDTH-1:0] din_re,
    input  logic [`PE_DATA_WIDTH-1:0] din_im,
    input  logic                      inst_in_v,
    input  logic [`PE_INST_WIDTH-1:0] inst_in,
    input  logic                      start,
    output logic                      dout_v,
    output logic [`PE_DATA_WIDTH-1:0] dout_re,
    output logic [`PE_DATA_WIDTH-1:0] dout_im,
    output logic                      fwd_v,
    output logic [`PE_DATA_WIDTH-1:0] fwd_re,
    output logic [`PE_DATA_WIDTH-1:0] fwd_im,
    output logic                      done,
    output logic                      busy
);

    pe_pkg::inst_t                 inst;
    pe_pkg::cplx_t                 fwd;
    pe_pkg::cplx_t                 wb_data;
    logic [`PE_REG_ADDR_WIDTH-1:0] wb_addr;
    logic                          wb_v;
    logic                          pc_en;
    logic                          pc_clr;

    pe_rf_if    rf ();
    pe_issue_if iss ();

    // program store, pc steered by control
    inst_mem u_inst_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .pc_en     (pc_en),
        .pc_clr    (pc_clr),
        .inst      (inst)
    );

    // operands, writeback and forwarding
    data_mem u_data_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .din_v   (din_v),
        .din     ({din_re, din_im}),
        .wb_v    (wb_v),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rf      (rf.mem),
        .fwd_v   (fwd_v),
        .fwd     (fwd)
    );

    pe_control u_pe_control (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .inst   (inst),
        .rf     (rf.ctrl),
        .iss    (iss.ctrl),
        .pc_en  (pc_en),
        .pc_clr (pc_clr),
        .busy   (busy)
    );

    complex_alu u_complex_alu (
        .clk     (clk),
        .arst_n  (arst_n),
        .iss     (iss.alu),
        .wb_v    (wb_v),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .dout_v  (dout_v),
        .done    (done)
    );

    // dout carries the writeback value
    assign dout_re = wb_data.re;
    assign dout_im = wb_data.im;
    assign fwd_re  = fwd.re;
    assign fwd_im  = fwd.im;

endmodule

//--- source/complex_alu.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module complex_alu (
    input  logic                          clk,
    input  logic                          arst_n,
    pe_issue_if.alu                       iss,
    output logic                          wb_v,
    output logic [`PE_REG_ADDR_WIDTH-1:0] wb_addr,
    output pe_pkg::cplx_t                 wb_data,
    output logic                          dout_v,
    output logic                          done
);

    // stage 1 tags
    logic                          s1_v;
    logic                          s1_halt;
    logic                          s1_out_en;
    logic [`PE_REG_ADDR_WIDTH-1:0] s1_dst;
    logic                          s1_neg_ii;
    logic                          s1_neg_ri;

    // partial products, or sums for add/sub
    logic [`PE_DATA_WIDTH-1:0] p_rr;
    logic [`PE_DATA_WIDTH-1:0] p_ii;
    logic [`PE_DATA_WIDTH-1:0] p_ri;
    logic [`PE_DATA_WIDTH-1:0] p_ir;

    // stage 2 tag
    logic s2_out_en;

    //////////////////////////////
    // valid and halt tags
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_v    <= 1'b0;
            s1_halt <= 1'b0;
            wb_v    <= 1'b0;
            done    <= 1'b0;
        end else begin
            s1_v    <= iss.issue_v;
            s1_halt <= iss.halt;
            wb_v    <= s1_v;
            done    <= s1_halt;
        end
    end

    //////////////////////////////
    // stage 1
    //////////////////////////////
    // low DATA_WIDTH bits kept, everything wraps
    always_ff @(posedge clk) begin
        s1_dst    <= iss.dst;
        s1_out_en <= iss.out_en;
        s1_neg_ii <= (iss.op == pe_pkg::OP_MUL);
        s1_neg_ri <= (iss.op == pe_pkg::OP_CMUL);
        case (iss.op)
            pe_pkg::OP_ADD: begin
                p_rr <= iss.a.re + iss.b.re;
                p_ir <= iss.a.im + iss.b.im;
                p_ii <= '0;
                p_ri <= '0;
            end
            pe_pkg::OP_SUB: begin
                p_rr <= iss.a.re - iss.b.re;
                p_ir <= iss.a.im - iss.b.im;
                p_ii <= '0;
                p_ri <= '0;
            end
            default: begin
                p_rr <= iss.a.re * iss.b.re;
                p_ii <= iss.a.im * iss.b.im;
                p_ri <= iss.a.re * iss.b.im;
                p_ir <= iss.a.im * iss.b.re;
            end
        endcase
    end

    //////////////////////////////
    // stage 2
    //////////////////////////////
    // mul:  re = rr - ii, im = ir + ri
    // cmul: re = rr + ii, im = ir - ri
    always_ff @(posedge clk) begin
        wb_addr   <= s1_dst;
        s2_out_en <= s1_out_en;
        wb_data.re <= s1_neg_ii ? (p_rr - p_ii) : (p_rr + p_ii);
        wb_data.im <= s1_neg_ri ? (p_ir - p_ri) : (p_ir + p_ri);
    end

    // results with out_en clear only go to the register file
    assign dout_v = wb_v && s2_out_en;

endmodule

//--- source/pe_control.sv
`timescale 1ns/1ps

module pe_control (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          start,
    input  pe_pkg::inst_t inst,
    pe_rf_if.ctrl         rf,
    pe_issue_if.ctrl      iss,
    output logic          pc_en,
    output logic          pc_clr,
    output logic          busy
);

    // fetch issues the program, run drains the alu after halt
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_RUN
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   drain_q;
    logic   in_fetch;
    logic   is_arith;
    logic   is_halt;

    //////////////////////////////
    // decode
    //////////////////////////////
    assign in_fetch = (state_q == ST_FETCH);
    assign is_halt  = (inst.op == pe_pkg::OP_HALT);
    assign is_arith = inst.op inside {pe_pkg::OP_ADD, pe_pkg::OP_SUB,
                                      pe_pkg::OP_MUL, pe_pkg::OP_CMUL};

    // operand fetch straight from the word
    assign rf.rd_addr_a = inst.src_a;
    assign rf.rd_addr_b = inst.src_b;

    assign busy = (state_q != ST_IDLE);

    //////////////////////////////
    // sequencing
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        pc_en   = 1'b0;
        pc_clr  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // start while busy never gets here
                if (start) begin
                    pc_clr  = 1'b1;
                    state_d = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (is_halt) begin
                    state_d = ST_RUN;
                end else begin
                    pc_en = 1'b1;
                end
            end
            ST_RUN: begin
                // two cycles, halt tag reaches the end of the pipe
                if (drain_q) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            drain_q     <= 1'b0;
            iss.issue_v <= 1'b0;
            iss.halt    <= 1'b0;
        end else begin
            state_q     <= state_d;
            drain_q     <= (state_q == ST_RUN) && !drain_q;
            // nop and undefined codes leave a bubble
            iss.issue_v <= in_fetch && is_arith;
            iss.halt    <= in_fetch && is_halt;
        end
    end

    // operands and tags
    always_ff @(posedge clk) begin
        iss.op     <= inst.op;
        iss.dst    <= inst.dst;
        iss.out_en <= inst.out_en;
        iss.a      <= rf.rd_a;
        iss.b      <= rf.rd_b;
    end

endmodule

//--- source/data_mem.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module data_mem (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          din_v,
    input  pe_pkg::cplx_t                 din,
    input  logic                          wb_v,
    input  logic [`PE_REG_ADDR_WIDTH-1:0] wb_addr,
    input  pe_pkg::cplx_t                 wb_data,
    pe_rf_if.mem                          rf,
    output logic                          fwd_v,
    output pe_pkg::cplx_t                 fwd
);

    pe_pkg::cplx_t regs [`PE_REG_NUM];

    logic [`PE_REG_ADDR_WIDTH:0]   ld_cnt;
    logic [`PE_REG_ADDR_WIDTH-1:0] ld_addr;
    logic                          ld_full;

    assign ld_addr = ld_cnt[`PE_REG_ADDR_WIDTH-1:0];
    assign ld_full = (ld_cnt == `PE_REG_NUM);

    //////////////////////////////
    // load counter and forward
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_cnt <= '0;
            fwd_v  <= 1'b0;
        end else begin
            if (din_v && !ld_full) begin
                ld_cnt <= ld_cnt + 1'b1;
            end
            // once full, everything goes to the next element
            fwd_v <= din_v && ld_full;
        end
    end

    always_ff @(posedge clk) begin
        if (din_v && ld_full) begin
            fwd <= din;
        end
    end

    //////////////////////////////
    // register file writes
    //////////////////////////////
    // writeback is last, so it wins on the same register
    always_ff @(posedge clk) begin
        if (din_v && !ld_full) begin
            regs[ld_addr] <= din;
        end
        if (wb_v) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // reads see a writeback landing on this edge
    always_comb begin
        rf.rd_a = regs[rf.rd_addr_a];
        rf.rd_b = regs[rf.rd_addr_b];
        if (wb_v && (wb_addr == rf.rd_addr_a)) begin
            rf.rd_a = wb_data;
        end
        if (wb_v && (wb_addr == rf.rd_addr_b)) begin
            rf.rd_b = wb_data;
        end
    end

endmodule

//--- source/inst_mem.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module inst_mem (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          inst_in_v,
    input  pe_pkg::inst_t inst_in,
    input  logic          pc_en,
    input  logic          pc_clr,
    output pe_pkg::inst_t inst
);

    pe_pkg::inst_t mem [`PE_IMEM_DEPTH];

    // one extra bit so the count can reach depth
    logic [`PE_PC_WIDTH:0]   ld_cnt;
    logic                    ld_full;
    logic [`PE_PC_WIDTH-1:0] pc;
    logic [`PE_PC_WIDTH-1:0] pc_nxt;

    assign ld_full = (ld_cnt == `PE_IMEM_DEPTH);

    //////////////////////////////
    // serial load
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_cnt <= '0;
        end else if (inst_in_v && !ld_full) begin
            ld_cnt <= ld_cnt + 1'b1;
        end
    end

    // words past the last entry are dropped
    always_ff @(posedge clk) begin
        if (inst_in_v && !ld_full) begin
            mem[ld_cnt[`PE_PC_WIDTH-1:0]] <= inst_in;
        end
    end

    //////////////////////////////
    // program counter
    //////////////////////////////
    always_comb begin
        pc_nxt = pc;
        if (pc_clr) begin
            pc_nxt = '0;
        end else if (pc_en) begin
            pc_nxt = pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_nxt;
        end
    end

    // read at next pc, so inst lines up with pc
    always_ff @(posedge clk) begin
        inst <= mem[pc_nxt];
    end

endmodule

//--- source/pe_if.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

// register file read, two ports
interface pe_rf_if;
    logic [`PE_REG_ADDR_WIDTH-1:0] rd_addr_a;
    logic [`PE_REG_ADDR_WIDTH-1:0] rd_addr_b;
    pe_pkg::cplx_t                 rd_a;
    pe_pkg::cplx_t                 rd_b;

    modport ctrl (output rd_addr_a, rd_addr_b, input rd_a, rd_b);
    modport mem (input rd_addr_a, rd_addr_b, output rd_a, rd_b);
endinterface

// issue from control into the alu pipe
interface pe_issue_if;
    logic                          issue_v;
    pe_pkg::op_e                   op;
    logic [`PE_REG_ADDR_WIDTH-1:0] dst;
    logic                          out_en;
    logic                          halt;
    pe_pkg::cplx_t                 a;
    pe_pkg::cplx_t                 b;

    modport ctrl (output issue_v, op, dst, out_en, halt, a, b);
    modport alu (input issue_v, op, dst, out_en, halt, a, b);
endinterface

//--- source/pe_pkg.sv
`include "pe_defs.svh"

package pe_pkg;

    // complex operand, re in the upper half
    typedef struct packed {
        logic [`PE_DATA_WIDTH-1:0] re;
        logic [`PE_DATA_WIDTH-1:0] im;
    } cplx_t;

    // opcodes, codes 6 and 7 decode as nop
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        // a times conj(b)
        OP_CMUL = 3'd4,
        OP_HALT = 3'd5
    } op_e;

    // instruction word, msb first
    typedef struct packed {
        op_e                           op;
        logic                          out_en;
        logic [`PE_REG_ADDR_WIDTH-1:0] dst;
        logic [`PE_REG_ADDR_WIDTH-1:0] src_a;
        logic [`PE_REG_ADDR_WIDTH-1:0] src_b;
    } inst_t;

endpackage

//--- source/pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// component width, real and imaginary each
`define PE_DATA_WIDTH 16

// one instruction word
`define PE_INST_WIDTH 16

// register file
`define PE_REG_NUM 16
`define PE_REG_ADDR_WIDTH 4

// instruction store and program counter
`define PE_IMEM_DEPTH 16
`define PE_PC_WIDTH 4

`endif
